/* hw/mipsDecodePkg.sv */
////////////////////////////////////////
// MIPS decode shared types
////////////////////////////////////////

package mipsDecodePkg;

    // Instruction symbols
    typedef enum logic [7:0] {
        opNop   = 8'd0,
        // R-type arithmetic and logic
        opAdd   = 8'd1,
        opSub   = 8'd2,
        opAddu  = 8'd3,
        opSubu  = 8'd4,
        opAnd   = 8'd5,
        opOr    = 8'd6,
        opXor   = 8'd7,
        opNor   = 8'd8,
        opSlt   = 8'd9,
        opSltu  = 8'd10,
        // R-type shifts
        opSll   = 8'd11,
        opSllv  = 8'd12,
        opSrl   = 8'd13,
        opSrlv  = 8'd14,
        opSra   = 8'd15,
        opSrav  = 8'd16,
        // Register jumps
        opJalr  = 8'd17,
        opJr    = 8'd18,
        // Immediate group
        opAddi  = 8'd19,
        opAddiu = 8'd20,
        opAndi  = 8'd21,
        opOri   = 8'd22,
        opXori  = 8'd23,
        opLui   = 8'd24,
        opSlti  = 8'd25,
        opSltiu = 8'd26,
        // Loads
        opLw    = 8'd27,
        opLh    = 8'd28,
        opLhu   = 8'd29,
        opLb    = 8'd30,
        opLbu   = 8'd31,
        // Stores
        opSw    = 8'd32,
        opSh    = 8'd33,
        opSb    = 8'd34,
        // Branches
        opBeq   = 8'd35,
        opBne   = 8'd36,
        opBlez  = 8'd37,
        opBgtz  = 8'd38,
        opBgez  = 8'd39,
        opBltz  = 8'd40,
        // Absolute jumps
        opJ     = 8'd41,
        opJal   = 8'd42
    } instrOp;

    typedef enum logic [3:0] {
        clsNop    = 4'd0,
        clsAlu    = 4'd1,
        clsAluImm = 4'd2,
        clsShift  = 4'd3,
        clsLoad   = 4'd4,
        clsStore  = 4'd5,
        clsBranch = 4'd6,
        clsJump   = 4'd7
    } instrClass;

    // Machine word handed to a lane
    typedef struct packed {
        logic [31:0] code;
    } decodeReq;

    // Lane result, packs to bits [17:0] of the read word
    typedef struct packed {
        logic      writesReg;
        logic [4:0] destReg;
        instrClass cls;
        instrOp    op;
    } decodeResult;

    // APB register map
    localparam logic [11:0] addrInstr  = 12'h000;
    localparam logic [11:0] addrResult = 12'h004;
    localparam logic [11:0] addrStatus = 12'h008;

    // Width of the status count field
    localparam int CountWidth = 8;

endpackage

/* hw/decodeDispatch.sv */
////////////////////////////////////////
// APB slave and lane dispatcher
////////////////////////////////////////
`timescale 1ns/100ps

module decodeDispatch #(
    parameter int NumLanes = 4
) (
    input  logic                                  clk,
    input  logic                                  rst,
    // APB slave
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [11:0]                           paddr,
    input  logic [31:0]                           pwdata,
    output logic [31:0]                           prdata,
    output logic                                  pready,
    output logic                                  pslverr,
    // Lane issue
    output logic [NumLanes-1:0]                   reqValid,
    output mipsDecodePkg::decodeReq               req,
    // Collector side
    input  logic                                  issueOk,
    input  mipsDecodePkg::decodeResult            headResult,
    input  logic [mipsDecodePkg::CountWidth-1:0]  fifoCount,
    input  logic                                  fifoEmpty,
    output logic                                  popReq
);

    localparam int LaneW  = (NumLanes > 1) ? $clog2(NumLanes) : 1;
    localparam int ResW   = $bits(mipsDecodePkg::decodeResult);
    localparam int CountW = mipsDecodePkg::CountWidth;

    logic             access;
    logic             instrWrite;
    logic             resultRead;
    logic             statusRead;
    logic             badWrite;
    logic             badRead;
    logic             issue;
    logic [LaneW-1:0] issuePtr;

    // Access phase decode
    assign access     = psel && penable;
    assign instrWrite = access && pwrite && (paddr == mipsDecodePkg::addrInstr);
    assign resultRead = access && !pwrite && (paddr == mipsDecodePkg::addrResult);
    assign statusRead = access && !pwrite && (paddr == mipsDecodePkg::addrStatus);
    assign badWrite   = access && pwrite && (paddr != mipsDecodePkg::addrInstr);
    assign badRead    = access && !pwrite && (paddr == mipsDecodePkg::addrInstr);

    // Instruction writes stall until the collector has room
    assign issue   = instrWrite && issueOk;
    assign pready  = access && (!instrWrite || issueOk);
    assign pslverr = badWrite || badRead || (resultRead && fifoEmpty);
    assign popReq  = resultRead && !fifoEmpty;

    assign req.code = pwdata;

    always_comb
    begin
        reqValid = '0;
        if (issue)
        begin
            reqValid[issuePtr] = 1'b1;
        end
    end

    // Read data mux
    always_comb
    begin
        prdata = '0;
        if (resultRead)
        begin
            prdata = {{(32 - ResW){1'b0}}, headResult};
        end
        else if (statusRead)
        begin
            prdata = {{(32 - CountW){1'b0}}, fifoCount};
        end
    end

    // Round-robin lane pointer
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            issuePtr <= '0;
        end
        else if (issue)
        begin
            if (issuePtr == LaneW'(NumLanes - 1))
            begin
                issuePtr <= '0;
            end
            else
            begin
                issuePtr <= issuePtr + 1'b1;
            end
        end
    end

endmodule

/* hw/instrDecoder.sv */
////////////////////////////////////////
// MIPS decode lane
////////////////////////////////////////
`timescale 1ns/100ps

module instrDecoder (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       reqValid,
    input  mipsDecodePkg::decodeReq    req,
    output logic                       resValid,
    output mipsDecodePkg::decodeResult res
);

    logic [5:0] opcode;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [5:0] funct;

    mipsDecodePkg::instrOp      op;
    mipsDecodePkg::instrClass   cls;
    logic [4:0]                 dest;
    logic                       hasDest;
    mipsDecodePkg::decodeResult decoded;

    // Word fields
    assign opcode = req.code[31:26];
    assign rt     = req.code[20:16];
    assign rd     = req.code[15:11];
    assign funct  = req.code[5:0];

    // R-type by funct
    function automatic mipsDecodePkg::instrOp functOp(input logic [5:0] f);
        case (f)
            6'b100000: functOp = mipsDecodePkg::opAdd;
            6'b100010: functOp = mipsDecodePkg::opSub;
            6'b100001: functOp = mipsDecodePkg::opAddu;
            6'b100011: functOp = mipsDecodePkg::opSubu;
            6'b100100: functOp = mipsDecodePkg::opAnd;
            6'b100101: functOp = mipsDecodePkg::opOr;
            6'b100110: functOp = mipsDecodePkg::opXor;
            6'b100111: functOp = mipsDecodePkg::opNor;
            6'b101010: functOp = mipsDecodePkg::opSlt;
            6'b101011: functOp = mipsDecodePkg::opSltu;
            6'b000000: functOp = mipsDecodePkg::opSll;
            6'b000100: functOp = mipsDecodePkg::opSllv;
            6'b000010: functOp = mipsDecodePkg::opSrl;
            6'b000110: functOp = mipsDecodePkg::opSrlv;
            6'b000011: functOp = mipsDecodePkg::opSra;
            6'b000111: functOp = mipsDecodePkg::opSrav;
            6'b001001: functOp = mipsDecodePkg::opJalr;
            6'b001000: functOp = mipsDecodePkg::opJr;
            default:   functOp = mipsDecodePkg::opNop;
        endcase
    endfunction

    // I and J types by opcode
    function automatic mipsDecodePkg::instrOp opcodeOp(input logic [5:0] o);
        case (o)
            6'b001000: opcodeOp = mipsDecodePkg::opAddi;
            6'b001001: opcodeOp = mipsDecodePkg::opAddiu;
            6'b001100: opcodeOp = mipsDecodePkg::opAndi;
            6'b001101: opcodeOp = mipsDecodePkg::opOri;
            6'b001110: opcodeOp = mipsDecodePkg::opXori;
            6'b001111: opcodeOp = mipsDecodePkg::opLui;
            6'b001010: opcodeOp = mipsDecodePkg::opSlti;
            6'b001011: opcodeOp = mipsDecodePkg::opSltiu;
            6'b100011: opcodeOp = mipsDecodePkg::opLw;
            6'b100001: opcodeOp = mipsDecodePkg::opLh;
            6'b100101: opcodeOp = mipsDecodePkg::opLhu;
            6'b100000: opcodeOp = mipsDecodePkg::opLb;
            6'b100100: opcodeOp = mipsDecodePkg::opLbu;
            6'b101011: opcodeOp = mipsDecodePkg::opSw;
            6'b101001: opcodeOp = mipsDecodePkg::opSh;
            6'b101000: opcodeOp = mipsDecodePkg::opSb;
            6'b000100: opcodeOp = mipsDecodePkg::opBeq;
            6'b000101: opcodeOp = mipsDecodePkg::opBne;
            6'b000110: opcodeOp = mipsDecodePkg::opBlez;
            6'b000111: opcodeOp = mipsDecodePkg::opBgtz;
            6'b000010: opcodeOp = mipsDecodePkg::opJ;
            6'b000011: opcodeOp = mipsDecodePkg::opJal;
            default:   opcodeOp = mipsDecodePkg::opNop;
        endcase
    endfunction

    function automatic mipsDecodePkg::instrClass classOf(input mipsDecodePkg::instrOp o);
        if (o == mipsDecodePkg::opNop)
            classOf = mipsDecodePkg::clsNop;
        else if (o <= mipsDecodePkg::opSltu)
            classOf = mipsDecodePkg::clsAlu;
        else if (o <= mipsDecodePkg::opSrav)
            classOf = mipsDecodePkg::clsShift;
        else if (o <= mipsDecodePkg::opJr)
            classOf = mipsDecodePkg::clsJump;
        else if (o <= mipsDecodePkg::opSltiu)
            classOf = mipsDecodePkg::clsAluImm;
        else if (o <= mipsDecodePkg::opLbu)
            classOf = mipsDecodePkg::clsLoad;
        else if (o <= mipsDecodePkg::opSb)
            classOf = mipsDecodePkg::clsStore;
        else if (o <= mipsDecodePkg::opBltz)
            classOf = mipsDecodePkg::clsBranch;
        else
            classOf = mipsDecodePkg::clsJump;
    endfunction

    // Symbol select, regimm only knows BGEZ and BLTZ
    always_comb
    begin
        if (req.code == 32'h0000_0000)
            op = mipsDecodePkg::opNop;
        else if (opcode == 6'b000000)
            op = functOp(funct);
        else if (opcode == 6'b000001)
            op = (rt == 5'd1) ? mipsDecodePkg::opBgez :
                 (rt == 5'd0) ? mipsDecodePkg::opBltz : mipsDecodePkg::opNop;
        else
            op = opcodeOp(opcode);
    end

    assign cls = classOf(op);

    // Destination register
    always_comb
    begin
        dest    = 5'd0;
        hasDest = 1'b0;
        if ((cls == mipsDecodePkg::clsAlu) || (cls == mipsDecodePkg::clsShift) ||
            (op == mipsDecodePkg::opJalr))
        begin
            dest    = rd;
            hasDest = 1'b1;
        end
        else if ((cls == mipsDecodePkg::clsAluImm) || (cls == mipsDecodePkg::clsLoad))
        begin
            dest    = rt;
            hasDest = 1'b1;
        end
        else if (op == mipsDecodePkg::opJal)
        begin
            // Link register
            dest    = 5'd31;
            hasDest = 1'b1;
        end
    end

    assign decoded.op        = op;
    assign decoded.cls       = cls;
    assign decoded.destReg   = dest;
    assign decoded.writesReg = hasDest && (dest != 5'd0);

    always_ff @(posedge clk)
    begin
        if (rst)
            resValid <= 1'b0;
        else
            resValid <= reqValid;
    end

    always_ff @(posedge clk)
    begin
        if (reqValid)
            res <= decoded;
    end

endmodule

/* hw/decodeCollect.sv */
////////////////////////////////////////
// In-order result collector
////////////////////////////////////////
`timescale 1ns/100ps

module decodeCollect #(
    parameter int NumLanes  = 4,
    parameter int FifoDepth = 8
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic [NumLanes-1:0]                           resValid,
    input  mipsDecodePkg::decodeResult [NumLanes-1:0]     res,
    input  logic                                          popReq,
    output logic                                          issueOk,
    output mipsDecodePkg::decodeResult                    headResult,
    output logic [mipsDecodePkg::CountWidth-1:0]          fifoCount,
    output logic                                          fifoEmpty
);

    localparam int LaneW  = (NumLanes > 1) ? $clog2(NumLanes) : 1;
    localparam int PtrW   = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
    localparam int CntW   = $clog2(FifoDepth + 1);
    localparam int CountW = mipsDecodePkg::CountWidth;

    mipsDecodePkg::decodeResult mem [FifoDepth];

    logic [LaneW-1:0] lanePtr;
    logic [PtrW-1:0]  wrPtr;
    logic [PtrW-1:0]  rdPtr;
    logic [CntW-1:0]  count;
    logic [LaneW:0]   inFlight;
    logic             push;
    logic             pop;

    assign push = resValid[lanePtr];
    assign pop  = popReq && (count != '0);

    // Lane results not yet in storage
    always_comb
    begin
        inFlight = '0;
        for (int i = 0; i < NumLanes; i++)
        begin
            inFlight = inFlight + (LaneW + 1)'(resValid[i]);
        end
    end

    assign issueOk    = (32'(count) + 32'(inFlight)) < 32'(FifoDepth);
    assign headResult = mem[rdPtr];
    assign fifoCount  = CountW'(count);
    assign fifoEmpty  = (count == '0);

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wrPtr] <= res[lanePtr];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            lanePtr <= '0;
            wrPtr   <= '0;
            rdPtr   <= '0;
            count   <= '0;
        end
        else
        begin
            // Follow the dispatcher's lane order
            if (push)
            begin
                lanePtr <= (lanePtr == LaneW'(NumLanes - 1)) ? '0 : lanePtr + 1'b1;
                wrPtr   <= (wrPtr == PtrW'(FifoDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop)
            begin
                rdPtr <= (rdPtr == PtrW'(FifoDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

endmodule

/* hw/decodeTop.sv */
////////////////////////////////////////
// MIPS decode accelerator top
////////////////////////////////////////
`timescale 1ns/100ps

module decodeTop #(
    parameter int NumLanes  = 4,
    parameter int FifoDepth = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic [NumLanes-1:0]                        reqValid;
    mipsDecodePkg::decodeReq                    req;
    logic [NumLanes-1:0]                        resValid;
    mipsDecodePkg::decodeResult [NumLanes-1:0]  res;
    logic                                       issueOk;
    mipsDecodePkg::decodeResult                 headResult;
    logic [mipsDecodePkg::CountWidth-1:0]       fifoCount;
    logic                                       fifoEmpty;
    logic                                       popReq;

    decodeDispatch #(
        .NumLanes(NumLanes)
    ) i_dispatch (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .reqValid   (reqValid),
        .req        (req),
        .issueOk    (issueOk),
        .headResult (headResult),
        .fifoCount  (fifoCount),
        .fifoEmpty  (fifoEmpty),
        .popReq     (popReq)
    );

    // All lanes share the request bus
    for (genvar g = 0; g < NumLanes; g++)
    begin : gLane
        instrDecoder i_lane (
            .clk      (clk),
            .rst      (rst),
            .reqValid (reqValid[g]),
            .req      (req),
            .resValid (resValid[g]),
            .res      (res[g])
        );
    end

    decodeCollect #(
        .NumLanes  (NumLanes),
        .FifoDepth (FifoDepth)
    ) i_collect (
        .clk        (clk),
        .rst        (rst),
        .resValid   (resValid),
        .res        (res),
        .popReq     (popReq),
        .issueOk    (issueOk),
        .headResult (headResult),
        .fifoCount  (fifoCount),
        .fifoEmpty  (fifoEmpty)
    );

endmodule

/* tests/decodeTop_assert.sv */
////////////////////////////////////////
// APB and FIFO protocol checks
////////////////////////////////////////
`timescale 1ns/100ps

module decodeTop_assert #(
    parameter int NumLanes  = 4,
    parameter int FifoDepth = 8
) (
    input logic                                 clk,
    input logic                                 rst,
    input logic                                 psel,
    input logic                                 penable,
    input logic                                 pwrite,
    input logic                                 pready,
    input logic                                 pslverr,
    input logic [NumLanes-1:0]                  reqValid,
    input logic [mipsDecodePkg::CountWidth-1:0] fifoCount
);

    int failCount = 0;

    // Completed transfer ends the access phase
    apbAccessEnd: assert property (@(posedge clk) disable iff (rst)
        (psel && penable && pready) |=> !penable)
    else
    begin
        $error("penable still high in the cycle after a completed transfer");
        failCount++;
    end

    fifoBound: assert property (@(posedge clk) disable iff (rst)
        fifoCount <= FifoDepth)
    else
    begin
        $error("FIFO count above its depth");
        failCount++;
    end

    // One lane issued per completed instruction write
    singleIssue: assert property (@(posedge clk) disable iff (rst)
        $onehot0(reqValid) &&
        ((reqValid != '0) == (psel && penable && pwrite && pready && !pslverr)))
    else
    begin
        $error("lane requests do not match the completed instruction writes");
        failCount++;
    end

endmodule

bind decodeTop decodeTop_assert #(
    .NumLanes  (NumLanes),
    .FifoDepth (FifoDepth)
) i_assert (
    .clk       (clk),
    .rst       (rst),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pready    (pready),
    .pslverr   (pslverr),
    .reqValid  (reqValid),
    .fifoCount (fifoCount)
);

/* tests/tb_decodeTop.sv */
////////////////////////////////////////
// MIPS decode accelerator testbench
////////////////////////////////////////
`timescale 1ns/100ps

module tb_decodeTop;

    localparam int NumLanes  = 4;
    localparam int FifoDepth = 8;
    localparam int MaxWords  = 256;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // Two header words, then word and expected result pairs
    logic [31:0] vecMem [MaxWords];
    int          numVec = 0;
    int          bpLen  = 0;
    logic        fileOk;

    logic [19:0] lfsrState  = 20'd88058;
    int          cycles     = 0;
    int          errCount   = 0;
    int          checkCount = 0;
    int          testCount  = 0;

    logic [31:0] rdata;
    logic        err;
    int          pick;
    logic [31:0] expQ [$];

    decodeTop #(
        .NumLanes  (NumLanes),
        .FifoDepth (FifoDepth)
    ) i_dut (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #50 clk = ~clk;

    // Run limit scales with the vector count
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= 40 * numVec + 200)
        begin
            $display("Timeout after %0d cycles, the DUT stopped completing transfers", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Taps 20 and 17
    function automatic logic [19:0] lfsrNext(input logic [19:0] s);
        lfsrNext = {s[18:0], s[19] ^ s[16]};
    endfunction

    task automatic drawBits(input int n, output int v);
        v = 0;
        for (int b = 0; b < n; b++)
        begin
            lfsrState = lfsrNext(lfsrState);
            v = (v << 1) | int'(lfsrState[0]);
        end
    endtask

    task automatic idleGap();
        int n;
        drawBits(2, n);
        repeat (n) @(posedge clk);
    endtask

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        if (got !== exp)
        begin
            errCount++;
            $display("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    // Setup, access, then wait states until pready
    task automatic apbTransfer(input logic write, input logic [11:0] addr,
                               input logic [31:0] data, output logic [31:0] rd,
                               output logic slvErr);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        while (!pready)
            @(posedge clk);
        rd      = prdata;
        slvErr  = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic writeInstr(input logic [31:0] word);
        apbTransfer(1'b1, mipsDecodePkg::addrInstr, word, rdata, err);
        checkEq("pslverr", 32'(err), 32'h0);
    endtask

    task automatic readResult(input logic [31:0] exp, input string name);
        apbTransfer(1'b0, mipsDecodePkg::addrResult, 32'h0, rdata, err);
        checkEq("pslverr", 32'(err), 32'h0);
        checkEq(name, rdata, exp);
    endtask

    task automatic expectStatus(input int exp);
        apbTransfer(1'b0, mipsDecodePkg::addrStatus, 32'h0, rdata, err);
        checkEq("pslverr", 32'(err), 32'h0);
        checkEq("status", rdata, 32'(exp));
    endtask

    task automatic finishTest(input string name, input int errStart);
        testCount++;
        $display("Test %0d %s: %0d errors", testCount, name, errCount - errStart);
    endtask

    task automatic singleDecode();
        int errStart;
        errStart = errCount;
        for (int i = 0; i < numVec; i++)
        begin
            writeInstr(vecMem[2 + 2 * i]);
            idleGap();
            readResult(vecMem[3 + 2 * i], $sformatf("prdata vector %0d", i));
        end
        finishTest("single decode", errStart);
    endtask

    task automatic laneOrder();
        int errStart;
        int burstLen;
        errStart = errCount;
        burstLen = NumLanes + 2;
        expQ.delete();
        for (int i = 0; i < burstLen; i++)
        begin
            drawBits(6, pick);
            pick = pick % numVec;
            expQ.push_back(vecMem[3 + 2 * pick]);
            writeInstr(vecMem[2 + 2 * pick]);
            idleGap();
        end
        expectStatus(burstLen);
        while (expQ.size() > 0)
        begin
            idleGap();
            readResult(expQ.pop_front(), "prdata burst");
        end
        finishTest("lane order", errStart);
    endtask

    task automatic backPressure();
        int errStart;
        errStart = errCount;
        if ((bpLen != FifoDepth + 1) || (bpLen > numVec))
        begin
            $display("Vector header back-pressure length %0d does not fit FIFO depth %0d",
                     bpLen, FifoDepth);
            errCount++;
        end
        else
        begin
            for (int i = 0; i < FifoDepth; i++)
                writeInstr(vecMem[2 + 2 * i]);
            expectStatus(FifoDepth);
            // Extra write stalls while the FIFO is full
            @(posedge clk);
            psel    <= 1'b1;
            penable <= 1'b0;
            pwrite  <= 1'b1;
            paddr   <= mipsDecodePkg::addrInstr;
            pwdata  <= vecMem[2 + 2 * FifoDepth];
            @(posedge clk);
            penable <= 1'b1;
            repeat (4)
            begin
                @(posedge clk);
                checkEq("pready", 32'(pready), 32'h0);
            end
            // Single port, so the stalled write steps aside for one pop
            psel    <= 1'b0;
            penable <= 1'b0;
            readResult(vecMem[3], "prdata full");
            writeInstr(vecMem[2 + 2 * FifoDepth]);
            for (int i = 1; i <= FifoDepth; i++)
                readResult(vecMem[3 + 2 * i], "prdata full");
            expectStatus(0);
        end
        finishTest("back-pressure", errStart);
    endtask

    task automatic statusCount();
        int errStart;
        int k;
        int j;
        errStart = errCount;
        drawBits(2, k);
        k = k + 3;
        drawBits(3, j);
        j = j % (k + 1);
        for (int i = 0; i < k; i++)
            writeInstr(vecMem[2 + 2 * i]);
        for (int i = 0; i < j; i++)
            readResult(vecMem[3 + 2 * i], "prdata status");
        expectStatus(k - j);
        for (int i = j; i < k; i++)
            readResult(vecMem[3 + 2 * i], "prdata status");
        expectStatus(0);
        finishTest("status count", errStart);
    endtask

    task automatic errorResponse();
        int errStart;
        errStart = errCount;
        writeInstr(vecMem[2]);
        apbTransfer(1'b1, mipsDecodePkg::addrStatus, 32'h5, rdata, err);
        checkEq("pslverr", 32'(err), 32'h1);
        apbTransfer(1'b0, mipsDecodePkg::addrInstr, 32'h0, rdata, err);
        checkEq("pslverr", 32'(err), 32'h1);
        expectStatus(1);
        readResult(vecMem[3], "prdata");
        // Empty FIFO read pops nothing
        apbTransfer(1'b0, mipsDecodePkg::addrResult, 32'h0, rdata, err);
        checkEq("pslverr", 32'(err), 32'h1);
        expectStatus(0);
        finishTest("error response", errStart);
    endtask

    task automatic destRule();
        int errStart;
        errStart = errCount;
        // jal links through $31
        writeInstr(32'h0C00_0100);
        apbTransfer(1'b0, mipsDecodePkg::addrResult, 32'h0, rdata, err);
        checkEq("pslverr", 32'(err), 32'h0);
        checkEq("destReg", 32'(rdata[16:12]), 32'd31);
        checkEq("writesReg", 32'(rdata[17]), 32'h1);
        // add $0 has no writeback
        writeInstr(32'h0085_0020);
        apbTransfer(1'b0, mipsDecodePkg::addrResult, 32'h0, rdata, err);
        checkEq("pslverr", 32'(err), 32'h0);
        checkEq("writesReg", 32'(rdata[17]), 32'h0);
        finishTest("destination", errStart);
    endtask

    initial
    begin
        clk     = 1'b0;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        $readmemh("tests/decode_vectors.txt", vecMem);
        numVec = int'(vecMem[0]);
        bpLen  = int'(vecMem[1]);
        fileOk = (numVec > 0) && (2 + 2 * numVec <= MaxWords);
        if (!fileOk)
        begin
            $display("Vector file is missing or holds a bad vector count");
            errCount++;
            numVec = 0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        if (fileOk)
        begin
            singleDecode();
            laneOrder();
            backPressure();
            statusCount();
            errorResponse();
            destRule();
        end
        repeat (2) @(posedge clk);
        if (i_dut.i_assert.failCount != 0)
            $display("Protocol assertions fired %0d times", i_dut.i_assert.failCount);
        $display("Tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 testCount, checkCount, errCount, i_dut.i_assert.failCount);
        if ((errCount == 0) && (i_dut.i_assert.failCount == 0))
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* tests/decode_vectors.txt */
// Header: vector count, back-pressure burst length (FifoDepth plus one)
// Vectors: instruction word, expected result {writesReg, destReg, cls, op}
0000002F 00000009
00851020 00022101 // add $2
00851822 00023102 // sub $3
00853021 00026103 // addu $6
00853823 00027104 // subu $7
00854024 00028105 // and $8
00854825 00029106 // or $9
00855026 0002A107 // xor $10
00855827 0002B108 // nor $11
0085602A 0002C109 // slt $12
0085682B 0002D10A // sltu $13
000570C0 0002E30B // sll $14
00857804 0002F30C // sllv $15
00058082 0003030D // srl $16
00858806 0003130E // srlv $17
00059043 0003230F // sra $18
00859807 00033310 // srav $19
0080F809 0003F711 // jalr $31
03E00008 00000712 // jr $31
21280001 00028213 // addi $8
2409FFFF 00029214 // addiu $9
312A00FF 0002A215 // andi $10
352B0001 0002B216 // ori $11
392C0001 0002C217 // xori $12
3C0D1234 0002D218 // lui $13
292E0005 0002E219 // slti $14
2D2F0005 0002F21A // sltiu $15
8FB00004 0003041B // lw $16
87B10004 0003141C // lh $17
97B20004 0003241D // lhu $18
83B30004 0003341E // lb $19
93B40004 0003441F // lbu $20
AFB00008 00000520 // sw
A7B00008 00000521 // sh
A3B00008 00000522 // sb
10850003 00000623 // beq
14850003 00000624 // bne
18800003 00000625 // blez
1C800003 00000626 // bgtz
04810003 00000627 // bgez
04800003 00000628 // bltz
08000100 00000729 // j
0C000100 0003F72A // jal
00000000 00000000 // zero word
FC000000 00000000 // unknown opcode
0000000C 00000000 // unknown funct
04820003 00000000 // unknown regimm rt
00850020 00000101 // add $0

/* sources.f */
hw/mipsDecodePkg.sv
hw/decodeDispatch.sv
hw/instrDecoder.sv
hw/decodeCollect.sv
hw/decodeTop.sv
tests/decodeTop_assert.sv
tests/tb_decodeTop.sv
